// ==== hw/ddr_types_pkg.sv ====
package ddr_types_pkg;

	localparam int bg_w   = 2;  // bank group bits
	localparam int bank_w = 2;  // bank bits inside a group
	localparam int row_w  = 14;
	localparam int col_w  = 10;
	localparam int slot_w = 3;  // enough for 8 slots

	typedef enum logic [2:0] {
		none,       // idle bus cycle
		activate,
		read_cmd,
		write_cmd,
		precharge
	} cmd_e;

	typedef enum logic {
		read,
		write
	} req_kind_e;

	typedef enum logic [1:0] {
		empty,
		full,           // waiting for its commands
		returning_data  // column cmd sent, frees next cycle
	} slot_state_e;

	typedef logic [slot_w-1:0] slot_idx_t;
	typedef logic [bg_w+bank_w-1:0] bank_id_t;  // {bank_group, bank}

	typedef struct packed {
		logic [bg_w-1:0]   bank_group;
		logic [bank_w-1:0] bank;
		logic [row_w-1:0]  row;
		logic [col_w-1:0]  column;
	} ddr_addr_t;  // 28 bits

	// column as seen on the shared address pins
	typedef struct packed {
		logic [row_w-col_w-1:0] pad;  // upper pins unused for column
		logic [col_w-1:0]       column;
	} col_view_t;

	typedef union packed {
		logic [row_w-1:0] row;  // on activate
		col_view_t        col;  // on read or write
	} dram_addr_u;

	typedef struct packed {
		cmd_e              cmd;
		logic [bg_w-1:0]   bank_group;
		logic [bank_w-1:0] bank;
		dram_addr_u        addr;
		slot_idx_t         slot;  // slot that owns the command
	} dram_cmd_t;

	typedef struct packed {
		cmd_e      cmd;
		slot_idx_t slot;
	} slot_grant_t;

endpackage

// ==== hw/ddr_timing_pkg.sv ====
package ddr_timing_pkg;

	localparam int banks_no       = 16;
	localparam int bank_groups_no = 4;

	localparam int act_to_rd            = 6;  // same bank, also act to wr
	localparam int pre_to_act           = 6;
	localparam int act_to_act_same_bank = 20;
	localparam int act_to_pre           = 14;
	localparam int rd_to_pre            = 3;
	localparam int wr_to_pre            = 6;
	localparam int rd_to_rd             = 2;  // column to column, same bank

	localparam int act_to_act_diff_bank = 3;  // within one bank group

	localparam int rd_to_wr   = 5;  // bus turnaround
	localparam int wr_to_rd   = 9;
	localparam int burst_time = 8;  // beats per burst
	localparam int rd_to_data = 6;
	localparam int wr_to_data = 4;

	localparam int slots_default = 4;

	localparam int col_to_col = burst_time / 2;  // 8 beats in 4 clocks on the bus
	localparam int cnt_w      = 5;               // holds every saturation value below

	// counters stop one below the largest gap they gate
	localparam int act_sat    = act_to_act_same_bank - 1;
	localparam int rd_sat     = ((rd_to_pre > rd_to_rd) ? rd_to_pre : rd_to_rd) - 1;
	localparam int wr_sat     = wr_to_pre - 1;
	localparam int pre_sat    = pre_to_act - 1;
	localparam int grp_sat    = act_to_act_diff_bank - 1;
	localparam int bus_rd_sat = burst_time + rd_to_data - 1;  // read data window
	localparam int bus_wr_sat = burst_time + wr_to_data - 1;  // write data window

endpackage

// ==== hw/burst_slots.sv ====
`timescale 1ns/1ps

module burst_slots import ddr_types_pkg::*, ddr_timing_pkg::*; #(
	parameter int no_of_slots = slots_default  // 2, 4 or 8
) (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             req_valid,  // one cycle pulse
	input  ddr_addr_t                        req_addr,
	input  req_kind_e                        req_kind,
	input  slot_grant_t                      grant,      // watched for column issue
	output slot_state_e [no_of_slots-1:0]    slot_state,
	output req_kind_e   [no_of_slots-1:0]    slot_kind,
	output ddr_addr_t   [no_of_slots-1:0]    slot_addr,
	output logic                             slots_full  // no empty slot left
);

	slot_state_e [no_of_slots-1:0] state_nxt;  // next state per slot
	slot_idx_t free_idx;                       // lowest empty slot
	logic accept;                              // request taken this cycle
	logic col_grant;                           // grant carries rd or wr
	logic full_nxt;                            // no empty slot after this edge

	assign accept    = req_valid & ~slots_full;  // pulse while full is lost
	assign col_grant = (grant.cmd == read_cmd) || (grant.cmd == write_cmd);

	always_comb begin
		free_idx = '0;
		for (int i = no_of_slots - 1; i >= 0; i--) begin  // descending so lowest wins
			if (slot_state[i] == empty) begin
				free_idx = slot_idx_t'(i);
			end
		end
	end

	always_comb begin
		state_nxt = slot_state;
		full_nxt  = 1'b1;
		for (int i = 0; i < no_of_slots; i++) begin
			if (slot_state[i] == returning_data) begin
				state_nxt[i] = empty;  // one cycle after its column cmd
			end
			if (col_grant && grant.slot == slot_idx_t'(i)) begin
				state_nxt[i] = returning_data;
			end
			if (accept && free_idx == slot_idx_t'(i)) begin
				state_nxt[i] = full;  // no write data path so full at once
			end
			if (state_nxt[i] == empty) begin
				full_nxt = 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst_n) begin  // sync, active high
			for (int i = 0; i < no_of_slots; i++) begin
				slot_state[i] <= empty;
			end
			slots_full <= 1'b0;
		end else begin
			slot_state <= state_nxt;
			slots_full <= full_nxt;
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < no_of_slots; i++) begin
			if (accept && free_idx == slot_idx_t'(i)) begin
				slot_addr[i] <= req_addr;  // held until the slot is refilled
				slot_kind[i] <= req_kind;
			end
		end
	end

endmodule

// ==== hw/timing_controller.sv ====
`timescale 1ns/1ps

module timing_controller import ddr_types_pkg::*, ddr_timing_pkg::*; #(
	parameter int no_of_slots = slots_default
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  slot_state_e [no_of_slots-1:0] slot_state,
	input  req_kind_e   [no_of_slots-1:0] slot_kind,
	input  ddr_addr_t   [no_of_slots-1:0] slot_addr,
	output slot_grant_t                   grant  // registered, none when idle
);

	logic [banks_no-1:0][row_w-1:0] open_row;  // row held open per bank
	logic [banks_no-1:0]            row_valid;
	logic [banks_no-1:0][cnt_w-1:0] bank_act_cnt;  // cycles since last ACT
	logic [banks_no-1:0][cnt_w-1:0] bank_rd_cnt;
	logic [banks_no-1:0][cnt_w-1:0] bank_wr_cnt;
	logic [banks_no-1:0][cnt_w-1:0] bank_pre_cnt;
	logic [bank_groups_no-1:0][cnt_w-1:0] grp_act_cnt;
	logic [cnt_w-1:0] bus_rd_cnt;  // since last RD on any bank
	logic [cnt_w-1:0] bus_wr_cnt;
	req_kind_e last_kind;          // kind of the last column cmd
	slot_idx_t rr_start;           // slot after the last winner

	bank_id_t [no_of_slots-1:0] slot_bank;
	logic     [no_of_slots-1:0] bus_ok;  // turnaround met for this slot's kind
	cmd_e     [no_of_slots-1:0] need_cmd;
	logic     [no_of_slots-1:0] elig;
	logic col_busy;  // column grant still visible to the slots

	logic [2*no_of_slots-1:0] rr_dbl, rr_back;
	logic [no_of_slots-1:0]   rr_rot, rr_one, rr_win;
	cmd_e      win_cmd;
	slot_idx_t win_idx;
	ddr_addr_t win_addr;
	bank_id_t  win_bank;

	function automatic logic gap_met(input logic [cnt_w-1:0] cnt, input int gap);
		return int'(cnt) >= gap - 1;  // one less, dram_cmd lags grant by a cycle
	endfunction

	function automatic logic [cnt_w-1:0] sat_inc(input logic [cnt_w-1:0] cnt, input int sat);
		return (int'(cnt) >= sat) ? cnt : cnt + 1'b1;
	endfunction

	assign col_busy = (grant.cmd == read_cmd) || (grant.cmd == write_cmd);
	assign win_bank = {win_addr.bank_group, win_addr.bank};

	always_comb begin
		for (int i = 0; i < no_of_slots; i++) begin
			slot_bank[i] = {slot_addr[i].bank_group, slot_addr[i].bank};
			if (slot_kind[i] == read) begin
				bus_ok[i] = (last_kind == read) ? gap_met(bus_rd_cnt, col_to_col)
				                                : gap_met(bus_wr_cnt, wr_to_rd);
			end else begin
				bus_ok[i] = (last_kind == write) ? gap_met(bus_wr_cnt, col_to_col)
				                                 : gap_met(bus_rd_cnt, rd_to_wr);
			end
		end
	end

	// pick the next command per slot and test its spacings
	always_comb begin
		for (int i = 0; i < no_of_slots; i++) begin
			need_cmd[i] = none;
			elig[i]     = 1'b0;
			if (slot_state[i] == full && !(col_busy && grant.slot == slot_idx_t'(i))) begin
				if (!row_valid[slot_bank[i]]) begin  // bank closed
					need_cmd[i] = activate;
					elig[i] = gap_met(bank_pre_cnt[slot_bank[i]], pre_to_act) &&
					          gap_met(bank_act_cnt[slot_bank[i]], act_to_act_same_bank) &&
					          gap_met(grp_act_cnt[slot_addr[i].bank_group], act_to_act_diff_bank);
				end else if (open_row[slot_bank[i]] != slot_addr[i].row) begin  // row miss
					need_cmd[i] = precharge;
					elig[i] = gap_met(bank_act_cnt[slot_bank[i]], act_to_pre) &&
					          gap_met(bank_rd_cnt[slot_bank[i]], rd_to_pre) &&
					          gap_met(bank_wr_cnt[slot_bank[i]], wr_to_pre);
				end else begin  // row hit
					need_cmd[i] = (slot_kind[i] == read) ? read_cmd : write_cmd;
					elig[i] = gap_met(bank_act_cnt[slot_bank[i]], act_to_rd) &&
					          gap_met(bank_rd_cnt[slot_bank[i]], rd_to_rd) &&
					          gap_met(bank_wr_cnt[slot_bank[i]], rd_to_rd) &&
					          bus_ok[i];
				end
			end
		end
	end

	always_comb begin
		rr_dbl  = {elig, elig} >> rr_start;   // rotate right to the start slot
		rr_rot  = rr_dbl[no_of_slots-1:0];
		rr_one  = rr_rot & (~rr_rot + 1'b1);  // first one
		rr_back = {rr_one, rr_one} << rr_start;
		rr_win  = rr_back[2*no_of_slots-1:no_of_slots];  // rotated back
		win_cmd  = none;
		win_idx  = '0;
		win_addr = '0;
		for (int i = 0; i < no_of_slots; i++) begin
			if (rr_win[i]) begin
				win_cmd  = need_cmd[i];
				win_idx  = slot_idx_t'(i);
				win_addr = slot_addr[i];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst_n) begin  // counters start saturated so nothing waits
			grant.cmd  <= none;
			grant.slot <= '0;
			row_valid  <= '0;
			for (int b = 0; b < banks_no; b++) begin
				bank_act_cnt[b] <= cnt_w'(act_sat);
				bank_rd_cnt[b]  <= cnt_w'(rd_sat);
				bank_wr_cnt[b]  <= cnt_w'(wr_sat);
				bank_pre_cnt[b] <= cnt_w'(pre_sat);
			end
			for (int g = 0; g < bank_groups_no; g++) begin
				grp_act_cnt[g] <= cnt_w'(grp_sat);
			end
			bus_rd_cnt <= cnt_w'(bus_rd_sat);
			bus_wr_cnt <= cnt_w'(bus_wr_sat);
			last_kind  <= read;
			rr_start   <= '0;
		end else begin
			for (int b = 0; b < banks_no; b++) begin
				bank_act_cnt[b] <= sat_inc(bank_act_cnt[b], act_sat);
				bank_rd_cnt[b]  <= sat_inc(bank_rd_cnt[b], rd_sat);
				bank_wr_cnt[b]  <= sat_inc(bank_wr_cnt[b], wr_sat);
				bank_pre_cnt[b] <= sat_inc(bank_pre_cnt[b], pre_sat);
			end
			for (int g = 0; g < bank_groups_no; g++) begin
				grp_act_cnt[g] <= sat_inc(grp_act_cnt[g], grp_sat);
			end
			bus_rd_cnt <= sat_inc(bus_rd_cnt, bus_rd_sat);
			bus_wr_cnt <= sat_inc(bus_wr_cnt, bus_wr_sat);
			grant.cmd  <= win_cmd;
			grant.slot <= win_idx;
			if (win_cmd != none) begin
				if (win_idx == slot_idx_t'(no_of_slots - 1)) begin
					rr_start <= '0;  // wrap
				end else begin
					rr_start <= win_idx + 1'b1;
				end
				case (win_cmd)  // restart the counters this cmd gates
					activate: begin
						bank_act_cnt[win_bank]              <= '0;
						grp_act_cnt[win_addr.bank_group]    <= '0;
						row_valid[win_bank]                 <= 1'b1;
					end
					read_cmd: begin
						bank_rd_cnt[win_bank] <= '0;
						bus_rd_cnt            <= '0;
						last_kind             <= read;
					end
					write_cmd: begin
						bank_wr_cnt[win_bank] <= '0;
						bus_wr_cnt            <= '0;
						last_kind             <= write;
					end
					precharge: begin
						bank_pre_cnt[win_bank] <= '0;
						row_valid[win_bank]    <= 1'b0;  // bank closed
					end
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (win_cmd == activate) begin
			open_row[win_bank] <= win_addr.row;  // qualified by row_valid
		end
	end

endmodule

// ==== hw/cmd_issuer.sv ====
`timescale 1ns/1ps

module cmd_issuer import ddr_types_pkg::*, ddr_timing_pkg::*; #(
	parameter int no_of_slots = slots_default
) (
	input  logic                        clk,
	input  logic                        rst_n,
	input  slot_grant_t                 grant,
	input  ddr_addr_t [no_of_slots-1:0] slot_addr,
	output dram_cmd_t                   dram_cmd  // registered command word
);

	ddr_addr_t  sel_addr;  // address of the granted slot
	dram_addr_u pins;      // row or column view by cmd

	always_comb begin
		sel_addr = '0;
		for (int i = 0; i < no_of_slots; i++) begin
			if (grant.slot == slot_idx_t'(i)) begin
				sel_addr = slot_addr[i];
			end
		end
	end

	always_comb begin
		pins = '0;  // precharge and idle drive zero
		case (grant.cmd)
			activate:            pins.row        = sel_addr.row;
			read_cmd, write_cmd: pins.col.column = sel_addr.column;  // pad stays zero
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_n) begin
			dram_cmd.cmd <= none;
		end else begin
			dram_cmd.cmd <= grant.cmd;  // none passes through when idle
		end
	end

	always_ff @(posedge clk) begin
		if (grant.cmd != none) begin  // fields only matter with a cmd
			dram_cmd.bank_group <= sel_addr.bank_group;
			dram_cmd.bank       <= sel_addr.bank;
			dram_cmd.addr       <= pins;
			dram_cmd.slot       <= grant.slot;
		end
	end

endmodule

// ==== hw/ddr_sched_top.sv ====
`timescale 1ns/1ps

module ddr_sched_top import ddr_types_pkg::*, ddr_timing_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      req_valid,
	input  ddr_addr_t req_addr,
	input  req_kind_e req_kind,
	output logic      slots_full,
	output dram_cmd_t dram_cmd
);

	slot_state_e [slots_default-1:0] slot_state;
	req_kind_e   [slots_default-1:0] slot_kind;
	ddr_addr_t   [slots_default-1:0] slot_addr;
	slot_grant_t grant;  // scheduler to issuer and slots

	burst_slots #(.no_of_slots(slots_default)) u_burst_slots (
		.clk        (clk),
		.rst_n      (rst_n),
		.req_valid  (req_valid),
		.req_addr   (req_addr),
		.req_kind   (req_kind),
		.grant      (grant),
		.slot_state (slot_state),
		.slot_kind  (slot_kind),
		.slot_addr  (slot_addr),
		.slots_full (slots_full)
	);

	timing_controller #(.no_of_slots(slots_default)) u_timing_controller (
		.clk        (clk),
		.rst_n      (rst_n),
		.slot_state (slot_state),
		.slot_kind  (slot_kind),
		.slot_addr  (slot_addr),
		.grant      (grant)
	);

	cmd_issuer #(.no_of_slots(slots_default)) u_cmd_issuer (
		.clk       (clk),
		.rst_n     (rst_n),
		.grant     (grant),
		.slot_addr (slot_addr),
		.dram_cmd  (dram_cmd)
	);

endmodule

// ==== verif/ddr_sched_chk.sv ====
`timescale 1ns/1ps

module ddr_sched_chk import ddr_types_pkg::*, ddr_timing_pkg::*; #(
	parameter int no_of_slots = slots_default
) (
	input logic                          clk,
	input logic                          rst_n,
	input slot_grant_t                   grant,
	input slot_state_e [no_of_slots-1:0] slot_state,
	input ddr_addr_t   [no_of_slots-1:0] slot_addr
);

	logic [7:0] act_age [banks_no];  // grants since last ACT, saturating
	bank_id_t   g_bank;              // bank of the granted slot
	logic       is_act;
	logic       is_col;
	int         fail_cnt;            // failed assertion count

	assign g_bank = {slot_addr[grant.slot].bank_group, slot_addr[grant.slot].bank};
	assign is_act = (grant.cmd == activate);
	assign is_col = (grant.cmd == read_cmd) || (grant.cmd == write_cmd);

	always_ff @(posedge clk) begin
		for (int b = 0; b < banks_no; b++) begin
			if (rst_n) begin
				act_age[b] <= 8'hff;
			end else if (is_act && g_bank == bank_id_t'(b)) begin
				act_age[b] <= 8'h00;
			end else if (act_age[b] != 8'hff) begin
				act_age[b] <= act_age[b] + 8'h01;
			end
		end
	end

	// age counts edges between two grants, so one less than the gap
	a_act_act: assert property (@(posedge clk) disable iff (rst_n)
		is_act |-> int'(act_age[g_bank]) >= act_to_act_same_bank - 1)
		else begin
			$error("ACT to ACT on one bank too close");
			fail_cnt++;
		end

	a_act_col: assert property (@(posedge clk) disable iff (rst_n)
		is_col |-> int'(act_age[g_bank]) >= act_to_rd - 1)
		else begin
			$error("ACT to column on one bank too close");
			fail_cnt++;
		end

	// granted slot still waits while its grant is visible
	a_grant_full: assert property (@(posedge clk) disable iff (rst_n)
		grant.cmd != none |-> slot_state[grant.slot] == full)
		else begin
			$error("grant to a slot that is not waiting for a command");
			fail_cnt++;
		end

	a_reset_none: assert property (@(posedge clk) rst_n |=> grant.cmd == none)
		else begin
			$error("grant not none during reset");
			fail_cnt++;
		end

endmodule

bind timing_controller ddr_sched_chk #(.no_of_slots(no_of_slots)) u_ddr_sched_chk (
	.clk        (clk),
	.rst_n      (rst_n),
	.grant      (grant),
	.slot_state (slot_state),
	.slot_addr  (slot_addr)
);

// ==== verif/tb_ddr_sched.sv ====
`timescale 1ns/1ps

module tb_ddr_sched import ddr_types_pkg::*, ddr_timing_pkg::*; ();

	localparam int total_reqs  = 51;                    // 1 + 2 + 4 + 4 + 40
	localparam int cycle_limit = total_reqs * 60 + 200;

	logic      clk = 1'b0;
	logic      rst_n;
	logic      req_valid;
	ddr_addr_t req_addr;
	req_kind_e req_kind;
	logic      slots_full;
	dram_cmd_t dram_cmd;

	logic [31:0]      lcg_state = 32'd89;
	logic [banks_no-1:0] tb_row_valid;          // model of open banks
	logic [row_w-1:0] tb_open_row [banks_no];
	dram_cmd_t        exp_q [banks_no][$];      // expected words per bank
	int cycle, errors, tests_ok, tests_bad, issued, completed;
	int last_act [banks_no];                    // cycle stamps per bank
	int last_brd [banks_no];
	int last_bwr [banks_no];
	int last_pre [banks_no];
	int last_rd, last_wr;                       // bus wide

	ddr_sched_top u_ddr_sched_top (
		.clk        (clk),
		.rst_n      (rst_n),
		.req_valid  (req_valid),
		.req_addr   (req_addr),
		.req_kind   (req_kind),
		.slots_full (slots_full),
		.dram_cmd   (dram_cmd)
	);

	always #4 clk = ~clk;  // 8 ns

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// PRE on a row miss, ACT unless the row is already open, then the column cmd
	function automatic int expect_seq(input ddr_addr_t a, input req_kind_e k,
		input slot_idx_t s, input logic open, input logic [row_w-1:0] row,
		output dram_cmd_t seq [3]);
		int n;
		dram_cmd_t w;
		n = 0;
		w = '0;
		w.bank_group = a.bank_group;
		w.bank       = a.bank;
		w.slot       = s;
		if (open && row != a.row) begin
			w.cmd  = precharge;
			w.addr = '0;  // no address on precharge
			seq[n] = w;
			n++;
		end
		if (!open || row != a.row) begin
			w.cmd      = activate;
			w.addr.row = a.row;
			seq[n]     = w;
			n++;
		end
		w.cmd             = (k == read) ? read_cmd : write_cmd;
		w.addr            = '0;
		w.addr.col.column = a.column;
		seq[n]            = w;
		n++;
		return n;
	endfunction

	task automatic check_cmd(input string name, input cmd_e got, input cmd_e exp);
		if (got !== exp) begin
			$display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_word(input dram_cmd_t got, input dram_cmd_t exp);
		if (got.bank_group !== exp.bank_group) begin
			$display("[ERROR] dram_cmd.bank_group got 0x%0h expected 0x%0h",
				got.bank_group, exp.bank_group);
			errors++;
		end
		if (got.bank !== exp.bank) begin
			$display("[ERROR] dram_cmd.bank got 0x%0h expected 0x%0h", got.bank, exp.bank);
			errors++;
		end
		if (got.addr !== exp.addr) begin
			$display("[ERROR] dram_cmd.addr got 0x%0h expected 0x%0h", got.addr, exp.addr);
			errors++;
		end
		if (got.slot !== exp.slot) begin
			$display("[ERROR] dram_cmd.slot got 0x%0h expected 0x%0h", got.slot, exp.slot);
			errors++;
		end
	endtask

	task automatic check_gap(input string name, input int gap, input int min_gap);
		if (gap < min_gap) begin
			$display("spacing %s too short at cycle %0d: %0d cycles, need %0d",
				name, cycle, gap, min_gap);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	// lower bounds only, then stamp the command
	task automatic check_spacing(input dram_cmd_t c, input int now);
		bank_id_t b;
		b = {c.bank_group, c.bank};
		case (c.cmd)
			activate: begin
				check_gap("pre_to_act", now - last_pre[b], pre_to_act);
				check_gap("act_to_act_same_bank", now - last_act[b], act_to_act_same_bank);
				for (int k = 0; k < banks_no / bank_groups_no; k++) begin
					if (bank_id_t'({c.bank_group, 2'(k)}) != b) begin
						check_gap("act_to_act_diff_bank", now - last_act[{c.bank_group, 2'(k)}],
							act_to_act_diff_bank);
					end
				end
				last_act[b] = now;
			end
			read_cmd: begin
				check_gap("act_to_rd", now - last_act[b], act_to_rd);
				check_gap("wr_to_rd", now - last_wr, wr_to_rd);
				last_brd[b] = now;
				last_rd     = now;
			end
			write_cmd: begin
				check_gap("act_to_wr", now - last_act[b], act_to_rd);
				check_gap("rd_to_wr", now - last_rd, rd_to_wr);
				last_bwr[b] = now;
				last_wr     = now;
			end
			precharge: begin
				check_gap("act_to_pre", now - last_act[b], act_to_pre);
				check_gap("rd_to_pre", now - last_brd[b], rd_to_pre);
				check_gap("wr_to_pre", now - last_bwr[b], wr_to_pre);
				last_pre[b] = now;
			end
			default: ;
		endcase
	endtask

	// monitor, cycle count and timeout in one process
	always @(posedge clk) begin
		bank_id_t  b;
		dram_cmd_t e;
		cycle = cycle + 1;
		if (cycle > cycle_limit) begin
			$display("timeout after %0d cycles, %0d of %0d requests done", cycle, completed, issued);
			$display("Simulation failed");
			$finish;
		end else if (!rst_n && dram_cmd.cmd != none) begin
			b = {dram_cmd.bank_group, dram_cmd.bank};
			check_spacing(dram_cmd, cycle);
			if (exp_q[b].size() == 0) begin
				$display("unexpected %s on bank %0d at cycle %0d", dram_cmd.cmd.name(), b, cycle);
				errors++;
			end else begin
				e = exp_q[b].pop_front();
				check_cmd("dram_cmd.cmd", dram_cmd.cmd, e.cmd);
				check_word(dram_cmd, e);
				if (e.cmd == read_cmd || e.cmd == write_cmd) begin
					completed++;  // request ends with its column cmd
				end
			end
		end
	end

	task automatic send(input ddr_addr_t a, input req_kind_e k, input slot_idx_t s);
		dram_cmd_t seq [3];
		bank_id_t  b;
		int n;
		b = {a.bank_group, a.bank};
		n = expect_seq(a, k, s, tb_row_valid[b], tb_open_row[b], seq);
		for (int i = 0; i < n; i++) begin
			exp_q[b].push_back(seq[i]);
		end
		tb_row_valid[b] = 1'b1;  // row stays open after the request
		tb_open_row[b]  = a.row;
		@(posedge clk);
		req_valid <= 1'b1;
		req_addr  <= a;
		req_kind  <= k;
		issued++;
	endtask

	task automatic idle_bus();
		@(posedge clk);
		req_valid <= 1'b0;
	endtask

	task automatic wait_all();
		while (completed < issued) begin
			@(negedge clk);
		end
		repeat (3) @(posedge clk);  // slots drain through returning_data
	endtask

	task automatic end_test(input string name, input int err_before);
		if (errors == err_before) begin
			tests_ok++;
			$display("test %s passed", name);
		end else begin
			tests_bad++;
			$display("test %s failed with %0d errors", name, errors - err_before);
		end
	endtask

	// distinct banks so each bank has one request in flight
	task automatic rand_group(input logic check_full);
		logic [banks_no-1:0] used;
		ddr_addr_t a;
		req_kind_e k;
		logic [31:0] r;
		used = '0;
		for (int i = 0; i < slots_default; i++) begin
			do begin
				r = lcg_next();
				a.bank_group = r[19:18];
				a.bank       = r[17:16];
			end while (used[{a.bank_group, a.bank}]);
			used[{a.bank_group, a.bank}] = 1'b1;
			r = lcg_next();
			a.row    = row_w'(r[21:20]);  // few rows so hits and misses both occur
			a.column = r[31:22];
			k        = req_kind_e'(r[16]);
			send(a, k, slot_idx_t'(i));
		end
		idle_bus();
		if (check_full) begin
			@(negedge clk);
			check_flag("slots_full", slots_full, 1'b1);
		end
		wait_all();
	endtask

	initial begin
		int e0;
		ddr_addr_t a;
		rst_n        = 1'b1;  // active high
		req_valid    = 1'b0;
		req_addr     = '0;
		req_kind     = read;
		tb_row_valid = '0;
		for (int b = 0; b < banks_no; b++) begin
			last_act[b] = -1000;
			last_brd[b] = -1000;
			last_bwr[b] = -1000;
			last_pre[b] = -1000;
		end
		last_rd = -1000;
		last_wr = -1000;

		e0 = errors;
		repeat (3) @(posedge clk);
		rst_n <= 1'b0;
		repeat (5) begin
			@(negedge clk);
			check_cmd("dram_cmd.cmd", dram_cmd.cmd, none);
			check_flag("slots_full", slots_full, 1'b0);
		end
		end_test("reset", e0);

		e0 = errors;
		a = '{bank_group: 2'd1, bank: 2'd2, row: 14'h0123, column: 10'h045};
		send(a, read, 3'd0);
		idle_bus();
		wait_all();
		end_test("idle_bank", e0);

		e0 = errors;
		a.column = 10'h046;
		send(a, read, 3'd0);  // row hit
		idle_bus();
		wait_all();
		a.row    = 14'h0200;
		a.column = 10'h3a1;
		send(a, write, 3'd0);  // row miss
		idle_bus();
		wait_all();
		end_test("row_hit_miss", e0);

		e0 = errors;
		for (int i = 0; i < slots_default; i++) begin
			a = '{bank_group: 2'd0, bank: 2'(i), row: 14'(i + 5), column: 10'(i * 8)};
			send(a, (i % 2 == 0) ? read : write, slot_idx_t'(i));  // turnaround both ways
		end
		idle_bus();
		wait_all();
		end_test("spacing", e0);

		e0 = errors;
		rand_group(1'b1);
		end_test("random_burst", e0);

		e0 = errors;
		for (int g = 0; g < 10; g++) begin
			rand_group(1'b0);
		end
		end_test("slot_reuse", e0);

		errors += u_ddr_sched_top.u_timing_controller.u_ddr_sched_chk.fail_cnt;  // bound checker
		$display("tests passed %0d failed %0d, errors %0d", tests_ok, tests_bad, errors);
		if (errors == 0 && tests_bad == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== tb.f ====
hw/ddr_types_pkg.sv
hw/ddr_timing_pkg.sv
hw/burst_slots.sv
hw/timing_controller.sv
hw/cmd_issuer.sv
hw/ddr_sched_top.sv
verif/ddr_sched_chk.sv
verif/tb_ddr_sched.sv

// ==== Makefile ====
TOP := tb_ddr_sched

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f tb.f -o sim

run: build
	./obj_dir/sim | tee sim.log
	grep -q "Simulation completed successfully" sim.log

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f tb.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
